// File: logic/dcache_geom_pkg.sv
`default_nettype none

package dcache_geom_pkg;

    // Address split into tag, index and offset
    localparam int OFFSET_BITS = 4;
    localparam int INDEX_BITS  = 6;
    localparam int TAG_BITS    = 22;
    localparam int NUM_SETS    = 1 << INDEX_BITS;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // Sixteen bytes with word 0 in the low bits
    typedef logic [127:0] line_t;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    // One bit names one of the two ways
    typedef logic way_t;

endpackage

`default_nettype wire

// File: logic/dcache_ctrl_pkg.sv
`default_nettype none

package dcache_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE          = 2'd0,
        REFILL        = 2'd1,
        WRITE_THROUGH = 2'd2
    } ctrl_state_t;

    // Command on the memory port
    typedef enum logic {
        MEM_RD = 1'b0,
        MEM_WR = 1'b1
    } mem_cmd_t;

endpackage

`default_nettype wire

// File: logic/dcache_line_merge.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_line_merge (
    input  wire dcache_geom_pkg::line_t base_line,
    input  wire [1:0]                   word_sel,
    input  wire dcache_geom_pkg::word_t store_data,
    input  wire dcache_geom_pkg::strb_t store_strb,
    output dcache_geom_pkg::line_t      merged_line
);

    logic [6:0] word_base;

    assign word_base = {word_sel, 5'b00000};

    always_comb begin
        merged_line = base_line;
        // Strobe bit b covers byte b of the selected word
        for (int b = 0; b < 4; b++) begin
            if (store_strb[b]) begin
                merged_line[word_base + b*8 +: 8] = store_data[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/dcache_ways.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ways (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire dcache_geom_pkg::addr_t  lookup_addr,
    output logic                         hit,
    output dcache_geom_pkg::way_t        hit_way,
    output dcache_geom_pkg::way_t        victim_way,
    output dcache_geom_pkg::line_t       hit_line,
    output dcache_geom_pkg::word_t       rdata,
    input  wire                          fill_en,
    input  wire dcache_geom_pkg::way_t   fill_way,
    input  wire dcache_geom_pkg::index_t fill_index,
    input  wire dcache_geom_pkg::tag_t   fill_tag,
    input  wire dcache_geom_pkg::line_t  fill_line,
    input  wire                          touch_en,
    input  wire dcache_geom_pkg::index_t touch_index,
    input  wire dcache_geom_pkg::way_t   touch_mru
);
    import dcache_geom_pkg::*;

    line_t data_mem [2][NUM_SETS];
    tag_t  tag_mem  [2][NUM_SETS];

    logic [NUM_SETS-1:0] valid_q [2];

    // Set bit names the least recently used way
    logic [NUM_SETS-1:0] lru_q;

    index_t     idx;
    tag_t       tag;
    logic [1:0] word_sel;
    logic [1:0] way_hit;

    assign idx      = lookup_addr[OFFSET_BITS +: INDEX_BITS];
    assign tag      = lookup_addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
    assign word_sel = lookup_addr[OFFSET_BITS-1:2];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_mem[w][idx] == tag);
        end
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign hit_line = data_mem[hit_way][idx];

    // Word select by address bits 3:2
    assign rdata = hit_line[word_sel*32 +: 32];

    assign victim_way = lru_q[idx];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[fill_way][fill_index] <= fill_line;
            tag_mem[fill_way][fill_index]  <= fill_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            lru_q      <= '0;
        end else begin
            if (fill_en) begin
                valid_q[fill_way][fill_index] <= 1'b1;
            end
            // Point away from the way just used
            if (touch_en) begin
                lru_q[touch_index] <= ~touch_mru;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire dcache_geom_pkg::addr_t  paddr,
    input  wire                          req,
    input  wire                          we,
    input  wire dcache_geom_pkg::word_t  wdata,
    input  wire dcache_geom_pkg::strb_t  wstrb,
    input  wire                          hit,
    input  wire dcache_geom_pkg::way_t   hit_way,
    input  wire dcache_geom_pkg::way_t   victim_way,
    input  wire dcache_geom_pkg::line_t  hit_line,
    output dcache_geom_pkg::line_t       merge_base,
    output logic [1:0]                   merge_sel,
    output dcache_geom_pkg::word_t       merge_data,
    output dcache_geom_pkg::strb_t       merge_strb,
    input  wire dcache_geom_pkg::line_t  merged_line,
    output logic                         fill_en,
    output dcache_geom_pkg::way_t        fill_way,
    output dcache_geom_pkg::index_t      fill_index,
    output dcache_geom_pkg::tag_t        fill_tag,
    output dcache_geom_pkg::line_t       fill_line,
    output logic                         touch_en,
    output dcache_geom_pkg::index_t      touch_index,
    output dcache_geom_pkg::way_t        touch_mru,
    output logic                         valid_out,
    output logic                         mem_req,
    output logic                         mem_we,
    output dcache_geom_pkg::addr_t       mem_addr,
    output dcache_geom_pkg::line_t       mem_wdata,
    input  wire dcache_geom_pkg::line_t  mem_rdata,
    input  wire                          mem_ready,
    input  wire dcache_geom_pkg::addr_t  mem_resp_addr
);
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;

    ctrl_state_t state;
    mem_cmd_t    mem_cmd;

    // Request held over a miss or a write-through
    addr_t miss_addr;
    word_t miss_wdata;
    strb_t miss_wstrb;
    logic  miss_we;
    way_t  miss_way;

    line_t wt_line;
    addr_t cur_addr;
    logic  accept;
    logic  resp_ok;
    logic  refill_done;

    // The cycle of valid_out still sees the old req, so skip it
    assign accept = (state == IDLE) && req && !valid_out;

    assign mem_addr    = {miss_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign resp_ok     = mem_ready && (mem_resp_addr == mem_addr);
    assign refill_done = (state == REFILL) && resp_ok;

    // Live store in IDLE, held store over the refill data
    always_comb begin
        if (state == REFILL) begin
            merge_base = mem_rdata;
            merge_sel  = miss_addr[3:2];
            merge_data = miss_wdata;
            merge_strb = miss_wstrb;
        end else begin
            merge_base = hit_line;
            merge_sel  = paddr[3:2];
            merge_data = wdata;
            merge_strb = wstrb;
        end
    end

    assign cur_addr   = (state == IDLE) ? paddr : miss_addr;
    assign fill_index = cur_addr[OFFSET_BITS +: INDEX_BITS];
    assign fill_tag   = cur_addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
    assign fill_way   = (state == IDLE) ? hit_way : miss_way;
    assign fill_line  = ((state == REFILL) && !miss_we) ? mem_rdata : merged_line;
    assign fill_en    = (accept && hit && we) || refill_done;

    // Hits and completed refills both make the way most recent
    assign touch_en    = (accept && hit) || refill_done;
    assign touch_index = fill_index;
    assign touch_mru   = fill_way;

    assign mem_req   = (state != IDLE);
    assign mem_cmd   = (state == WRITE_THROUGH) ? MEM_WR : MEM_RD;
    assign mem_we    = mem_req && (mem_cmd == MEM_WR);
    assign mem_wdata = wt_line;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            valid_out <= 1'b0;
            miss_we   <= 1'b0;
        end else begin
            valid_out <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        miss_we <= we;
                        if (!hit) begin
                            state <= REFILL;
                        end else if (we) begin
                            state <= WRITE_THROUGH;
                        end else begin
                            valid_out <= 1'b1;
                        end
                    end
                end
                REFILL: begin
                    // A wrong response address leaves the read request up
                    if (resp_ok) begin
                        state <= miss_we ? WRITE_THROUGH : IDLE;
                    end
                end
                WRITE_THROUGH: begin
                    if (mem_ready) begin
                        state     <= IDLE;
                        valid_out <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            miss_addr  <= paddr;
            miss_wdata <= wdata;
            miss_wstrb <= wstrb;
            miss_way   <= victim_way;
        end
        if ((accept && hit && we) || (refill_done && miss_we)) begin
            wt_line <= merged_line;
        end
    end

endmodule

`default_nettype wire

// File: logic/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire dcache_geom_pkg::addr_t paddr,
    input  wire                         req,
    input  wire                         we,
    input  wire dcache_geom_pkg::word_t wdata,
    input  wire dcache_geom_pkg::strb_t wstrb,
    output dcache_geom_pkg::word_t      rdata,
    output logic                        valid_out,
    output logic                        stall_cpu,
    output logic                        mem_req,
    output logic                        mem_we,
    output dcache_geom_pkg::addr_t      mem_addr,
    output dcache_geom_pkg::line_t      mem_wdata,
    input  wire dcache_geom_pkg::line_t mem_rdata,
    input  wire                         mem_ready,
    input  wire dcache_geom_pkg::addr_t mem_resp_addr
);
    import dcache_geom_pkg::*;

    logic       hit;
    way_t       hit_way;
    way_t       victim_way;
    line_t      hit_line;

    line_t      merge_base;
    logic [1:0] merge_sel;
    word_t      merge_data;
    strb_t      merge_strb;
    line_t      merged_line;

    logic       fill_en;
    way_t       fill_way;
    index_t     fill_index;
    tag_t       fill_tag;
    line_t      fill_line;
    logic       touch_en;
    index_t     touch_index;
    way_t       touch_mru;

    assign stall_cpu = req && !hit;

    dcache_ways u_ways (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (paddr),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .hit_line    (hit_line),
        .rdata       (rdata),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_index  (fill_index),
        .fill_tag    (fill_tag),
        .fill_line   (fill_line),
        .touch_en    (touch_en),
        .touch_index (touch_index),
        .touch_mru   (touch_mru)
    );

    dcache_line_merge u_merge (
        .base_line   (merge_base),
        .word_sel    (merge_sel),
        .store_data  (merge_data),
        .store_strb  (merge_strb),
        .merged_line (merged_line)
    );

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .paddr         (paddr),
        .req           (req),
        .we            (we),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .hit_line      (hit_line),
        .merge_base    (merge_base),
        .merge_sel     (merge_sel),
        .merge_data    (merge_data),
        .merge_strb    (merge_strb),
        .merged_line   (merged_line),
        .fill_en       (fill_en),
        .fill_way      (fill_way),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_line     (fill_line),
        .touch_en      (touch_en),
        .touch_index   (touch_index),
        .touch_mru     (touch_mru),
        .valid_out     (valid_out),
        .mem_req       (mem_req),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .mem_ready     (mem_ready),
        .mem_resp_addr (mem_resp_addr)
    );

endmodule

`default_nettype wire

// File: verif/dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
    input wire                               clk,
    input wire                               rst_n,
    input wire dcache_ctrl_pkg::ctrl_state_t state,
    input wire                               req,
    input wire                               we,
    input wire                               hit,
    input wire                               valid_out,
    input wire                               mem_req,
    input wire                               mem_ready,
    input wire dcache_geom_pkg::addr_t       mem_addr
);
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;

    logic read_hit;

    // Same acceptance condition as the controller
    assign read_hit = (state == IDLE) && req && !valid_out && hit && !we;

    a_line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> (mem_addr[OFFSET_BITS-1:0] == '0))
        else $error("mem_addr is not line aligned during a memory request");

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && !mem_ready) |=> mem_req)
        else $error("mem_req dropped before mem_ready");

    a_no_valid_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
        (state == REFILL) |-> !valid_out)
        else $error("valid_out high during refill");

    a_read_hit_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        read_hit |=> !mem_req)
        else $error("memory request after a read hit");

endmodule

bind dcache_ctrl dcache_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .req       (req),
    .we        (we),
    .hit       (hit),
    .valid_out (valid_out),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr)
);

`default_nettype wire

// File: verif/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_geom_pkg::*;

    localparam int    RESET_CYCLES = 5;
    localparam word_t PATTERN_KEY  = 32'h3C5A_96E1;
    localparam addr_t LINE_MASK    = 32'hFFFF_FFF0;

    typedef enum logic {OP_RD, OP_WR} op_t;

    typedef struct packed {
        op_t   op;
        addr_t addr;
        word_t data;
        strb_t strb;
        logic  bad;
        logic  miss;
    } entry_t;

    logic  clk;
    logic  rst_n;
    addr_t paddr;
    logic  req;
    logic  we;
    word_t wdata;
    strb_t wstrb;
    word_t rdata;
    logic  valid_out;
    logic  stall_cpu;
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    line_t mem_wdata;
    line_t mem_rdata;
    logic  mem_ready;
    addr_t mem_resp_addr;

    entry_t tbl[$];
    entry_t cur;
    line_t  shadow [addr_t];
    integer seed = 8;
    int     lat;
    logic   busy;
    logic   bad_pending;
    logic   bad_sent;
    int     rd_starts;
    int     wr_starts;
    int     cycles;
    int     cycle_limit;

    dcache u_dcache (
        .clk           (clk),
        .rst_n         (rst_n),
        .paddr         (paddr),
        .req           (req),
        .we            (we),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .rdata         (rdata),
        .valid_out     (valid_out),
        .stall_cpu     (stall_cpu),
        .mem_req       (mem_req),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .mem_ready     (mem_ready),
        .mem_resp_addr (mem_resp_addr)
    );

    always #20 clk = ~clk;

    // Lines are sixteen bytes
    function automatic addr_t line_of(input addr_t a);
        return a & LINE_MASK;
    endfunction

    // Untouched memory holds each word's address XOR a key
    function automatic line_t get_line(input addr_t line_addr);
        line_t l;
        if (shadow.exists(line_addr)) begin
            return shadow[line_addr];
        end
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = (line_addr | addr_t'(w * 4)) ^ PATTERN_KEY;
        end
        return l;
    endfunction

    function automatic word_t read_expect(input addr_t a);
        line_t l;
        l = get_line(line_of(a));
        return l[int'(a[3:2])*32 +: 32];
    endfunction

    function automatic line_t merge_expect(input line_t base, input addr_t a,
                                           input word_t data, input strb_t strb);
        line_t l;
        int    pos;
        l = base;
        for (int b = 0; b < 4; b++) begin
            pos = int'(a[3:2]) * 32 + b * 8;
            if (strb[b]) begin
                l[pos +: 8] = data[b*8 +: 8];
            end
        end
        return l;
    endfunction

    task automatic stop_on_error();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_on_error();
    endtask

    task automatic add_entry(input op_t op, input addr_t addr, input word_t data,
                             input strb_t strb, input logic bad, input logic miss);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        e.data = data;
        e.strb = strb;
        e.bad  = bad;
        e.miss = miss;
        tbl.push_back(e);
    endtask

    // Memory model serving one request at a time with 1 to 4 cycles of latency
    always @(negedge clk) begin
        if (!rst_n) begin
            mem_ready = 1'b0;
            busy      = 1'b0;
            bad_sent  = 1'b0;
        end else if (mem_ready) begin
            mem_ready = 1'b0;
            // The same line stays requested after a wrong response
            if (bad_sent) begin
                check_bit("mem_req", mem_req, 1'b1);
                bad_sent = 1'b0;
            end
        end else if (mem_req) begin
            if (!busy) begin
                busy = 1'b1;
                lat  = ($random(seed) & 3) + 1;
                check_addr("mem_addr", mem_addr, line_of(cur.addr));
                if (mem_we) begin
                    wr_starts++;
                    check_line("mem_wdata", mem_wdata,
                               merge_expect(get_line(mem_addr), cur.addr, cur.data, cur.strb));
                end else begin
                    rd_starts++;
                end
            end
            lat--;
            if (lat == 0) begin
                busy          = 1'b0;
                mem_ready     = 1'b1;
                mem_resp_addr = mem_addr;
                if (mem_we) begin
                    shadow[mem_addr] = mem_wdata;
                end else if (bad_pending) begin
                    // Response for another line with junk data
                    mem_resp_addr = mem_addr ^ 32'h0000_1000;
                    mem_rdata     = ~get_line(mem_addr);
                    bad_pending   = 1'b0;
                    bad_sent      = 1'b1;
                end else begin
                    mem_rdata = get_line(mem_addr);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles without finishing the table", cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        int exp_rd;
        int exp_wr;
        clk           = 1'b0;
        rst_n         = 1'b0;
        paddr         = '0;
        req           = 1'b0;
        we            = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        mem_rdata     = '0;
        mem_ready     = 1'b0;
        mem_resp_addr = '0;
        busy          = 1'b0;
        bad_pending   = 1'b0;
        bad_sent      = 1'b0;
        cycles        = 0;
        cur           = '0;

        // op, addr, wdata, wstrb, bad response, expect miss
        add_entry(OP_RD, 32'h0000_0104, 32'h0, 4'h0, 1'b0, 1'b1);
        add_entry(OP_RD, 32'h0000_0108, 32'h0, 4'h0, 1'b0, 1'b0);
        add_entry(OP_RD, 32'h0000_0104, 32'h0, 4'h0, 1'b0, 1'b0);
        add_entry(OP_WR, 32'h0000_0108, 32'hDEAD_BEEF, 4'b0101, 1'b0, 1'b0);
        add_entry(OP_RD, 32'h0000_0108, 32'h0, 4'h0, 1'b0, 1'b0);
        add_entry(OP_WR, 32'h0000_0A2C, 32'h1234_5678, 4'b1100, 1'b0, 1'b1);
        add_entry(OP_RD, 32'h0000_0A2C, 32'h0, 4'h0, 1'b0, 1'b0);
        // A, B and C share set 5
        add_entry(OP_RD, 32'h0000_1050, 32'h0, 4'h0, 1'b0, 1'b1);
        add_entry(OP_RD, 32'h0000_2054, 32'h0, 4'h0, 1'b0, 1'b1);
        add_entry(OP_RD, 32'h0000_1058, 32'h0, 4'h0, 1'b0, 1'b0);
        add_entry(OP_RD, 32'h0000_305C, 32'h0, 4'h0, 1'b0, 1'b1);
        add_entry(OP_RD, 32'h0000_1050, 32'h0, 4'h0, 1'b0, 1'b0);
        add_entry(OP_RD, 32'h0000_2050, 32'h0, 4'h0, 1'b0, 1'b1);
        add_entry(OP_RD, 32'h0000_105C, 32'h0, 4'h0, 1'b0, 1'b0);
        add_entry(OP_RD, 32'h0000_4340, 32'h0, 4'h0, 1'b1, 1'b1);
        add_entry(OP_RD, 32'h0000_4344, 32'h0, 4'h0, 1'b0, 1'b0);
        add_entry(OP_WR, 32'h0000_0100, 32'hCAFE_F00D, 4'b1111, 1'b0, 1'b0);
        add_entry(OP_WR, 32'h0000_5A20, 32'h0000_AB00, 4'b0010, 1'b1, 1'b1);
        add_entry(OP_RD, 32'h0000_5A20, 32'h0, 4'h0, 1'b0, 1'b0);
        add_entry(OP_RD, 32'h0000_0100, 32'h0, 4'h0, 1'b0, 1'b0);
        cycle_limit = tbl.size() * 20 + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < tbl.size(); i++) begin
            @(negedge clk);
            cur         = tbl[i];
            rd_starts   = 0;
            wr_starts   = 0;
            bad_pending = cur.bad;
            paddr       = cur.addr;
            we          = (cur.op == OP_WR);
            wdata       = cur.data;
            wstrb       = cur.strb;
            req         = 1'b1;
            #1;
            check_bit("stall_cpu", stall_cpu, cur.miss);

            @(negedge clk);
            while (!valid_out) @(negedge clk);
            if (cur.op == OP_RD) begin
                check_word("rdata", rdata, read_expect(cur.addr));
            end

            // A miss refills once, plus once per wrong response
            exp_rd = cur.miss ? 1 + int'(cur.bad) : 0;
            exp_wr = (cur.op == OP_WR) ? 1 : 0;
            if (rd_starts != exp_rd) begin
                report_failure($sformatf("Entry %0d made %0d refill reads instead of %0d",
                                         i, rd_starts, exp_rd));
            end
            if (wr_starts != exp_wr) begin
                report_failure($sformatf("Entry %0d made %0d memory writes instead of %0d",
                                         i, wr_starts, exp_wr));
            end
            req = 1'b0;
        end

        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/dcache_geom_pkg.sv
logic/dcache_ctrl_pkg.sv
logic/dcache_line_merge.sv
logic/dcache_ways.sv
logic/dcache_ctrl.sv
logic/dcache.sv
verif/dcache_checker.sv
verif/dcache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module dcache_tb -f build.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vdcache_tb 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
